//--- hw/lsu_cfg_pkg.sv
`default_nettype none

package lsu_cfg_pkg;

  // --------------------
  // Data and addresses
  // --------------------
  localparam int XLEN_W = 32;
  localparam int ADDR_W = 16;
  localparam int IMM_W  = 12;
  // Byte offset bits inside one word
  localparam int BOFS_W = $clog2(XLEN_W / 8);

  // --------------------
  // L1 data cache
  // --------------------
  localparam int LINE_WORDS = 4;
  localparam int LINE_W     = LINE_WORDS * XLEN_W;
  localparam int LINE_NUM   = 16;
  localparam int OFS_W      = $clog2(LINE_WORDS);
  localparam int IDX_W      = $clog2(LINE_NUM);
  localparam int CTAG_W     = ADDR_W - IDX_W - OFS_W - BOFS_W;

  // --------------------
  // Store queue, tags
  // --------------------
  localparam int SQ_DEPTH = 4;
  localparam int SQ_PTR_W = $clog2(SQ_DEPTH);
  localparam int SQ_CNT_W = $clog2(SQ_DEPTH + 1);
  localparam int TAG_W    = 4;

endpackage

`default_nettype wire

//--- hw/lsu_types_pkg.sv
`default_nettype none

package lsu_types_pkg;
  import lsu_cfg_pkg::*;

  // --------------------
  // Core side
  // --------------------
  // Memory op from dispatch, register operands already read
  typedef struct packed {
    logic              valid;
    logic              is_store;
    logic [TAG_W-1:0]  tag;
    logic [XLEN_W-1:0] base;
    logic [IMM_W-1:0]  offset;
    logic [XLEN_W-1:0] data;
  } disp_t;

  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [XLEN_W-1:0] data;
  } wr_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
    logic             is_store;
  } done_t;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } commit_t;

  // --------------------
  // Store queue traffic
  // --------------------
  typedef struct packed {
    logic              valid;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [XLEN_W-1:0] data;
  } sq_push_t;

  typedef struct packed {
    logic              hit;
    logic [XLEN_W-1:0] data;
  } sq_fwd_t;

  // Also the cache word write, gated by the drain ack
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [XLEN_W-1:0] data;
  } sq_drain_t;

  // --------------------
  // Memory and cache
  // --------------------
  // Read carries a line address, write a word address
  typedef struct packed {
    logic              valid;
    logic              is_write;
    logic [ADDR_W-1:0] addr;
    logic [XLEN_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic              valid;
    logic [LINE_W-1:0] line;
  } mem_resp_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [LINE_W-1:0] line;
  } refill_t;

  // Page table walker port
  typedef enum logic [1:0] {
    NONE,
    HIT,
    MISS
  } ptw_status_e;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
  } ptw_req_t;

  typedef struct packed {
    logic              valid;
    ptw_status_e       status;
    logic [XLEN_W-1:0] data;
  } ptw_resp_t;

endpackage

`default_nettype wire

//--- hw/lsu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_pipe
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  disp_t             i_disp,
  output logic [ADDR_W-1:0] o_rd_addr,
  input  logic              i_rd_hit,
  input  logic [XLEN_W-1:0] i_rd_data,
  output logic [ADDR_W-1:0] o_fwd_addr,
  input  sq_fwd_t           i_fwd,
  output sq_push_t          o_sq_push,
  output logic [1:0]        o_st_pend,
  output logic              o_miss_valid,
  output logic [ADDR_W-1:0] o_miss_addr,
  input  logic              i_refill_done,
  output logic              o_stall,
  output wr_t               o_ex3_wr,
  output done_t             o_done
);

  typedef struct packed {
    logic              valid;
    logic              is_store;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [XLEN_W-1:0] data;
  } ex2_t;

  typedef struct packed {
    logic              valid;
    logic              is_store;
    logic [TAG_W-1:0]  tag;
    logic [XLEN_W-1:0] data;
  } ex3_t;

  disp_t             r_ex1;
  ex2_t              r_ex2;
  ex3_t              r_ex3;
  logic [XLEN_W-1:0] w_ex1_sum;
  logic [ADDR_W-1:0] w_ex1_addr;
  logic              w_ex2_ld;
  logic              r_miss_pend;
  logic              r_replay;

  // --------------------
  // EX1
  // --------------------
  assign w_ex1_sum  = r_ex1.base + {{(XLEN_W - IMM_W){r_ex1.offset[IMM_W-1]}}, r_ex1.offset};
  assign w_ex1_addr = w_ex1_sum[ADDR_W-1:0];

  // While EX2 waits the cache keeps re-reading its address
  assign o_rd_addr = o_stall ? r_ex2.addr : w_ex1_addr;

  // --------------------
  // EX2
  // --------------------
  assign w_ex2_ld   = r_ex2.valid & ~r_ex2.is_store;
  assign o_fwd_addr = r_ex2.addr;

  // Cache data is stale until one read after the refill landed
  assign o_stall      = w_ex2_ld & ~i_fwd.hit & (~i_rd_hit | r_miss_pend | r_replay);
  assign o_miss_valid = w_ex2_ld & ~i_fwd.hit & ~i_rd_hit & ~r_miss_pend & ~r_replay;
  assign o_miss_addr  = {r_ex2.addr[ADDR_W-1:OFS_W+BOFS_W], {(OFS_W + BOFS_W){1'b0}}};

  assign o_sq_push = '{valid: r_ex2.valid & r_ex2.is_store, tag: r_ex2.tag,
                       addr: r_ex2.addr, data: r_ex2.data};

  // Stores not yet counted by the queue
  assign o_st_pend = {1'b0, r_ex1.valid & r_ex1.is_store} + {1'b0, r_ex2.valid & r_ex2.is_store};

  // --------------------
  // EX3
  // --------------------
  assign o_ex3_wr = '{valid: r_ex3.valid & ~r_ex3.is_store, tag: r_ex3.tag, data: r_ex3.data};
  assign o_done   = '{valid: r_ex3.valid, tag: r_ex3.tag, is_store: r_ex3.is_store};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1.valid <= 1'b0;
      r_ex2.valid <= 1'b0;
      r_ex3.valid <= 1'b0;
      r_miss_pend <= 1'b0;
      r_replay    <= 1'b0;
    end else begin
      if (!o_stall) begin
        r_ex1 <= i_disp;
        r_ex2 <= '{valid: r_ex1.valid, is_store: r_ex1.is_store, tag: r_ex1.tag,
                   addr: w_ex1_addr, data: r_ex1.data};
      end
      // Bubble into EX3 while EX2 holds
      r_ex3 <= '{valid: r_ex2.valid & ~o_stall, is_store: r_ex2.is_store, tag: r_ex2.tag,
                 data: i_fwd.hit ? i_fwd.data : i_rd_data};
      if (o_miss_valid) begin
        r_miss_pend <= 1'b1;
      end else if (i_refill_done) begin
        r_miss_pend <= 1'b0;
      end
      r_replay <= i_refill_done;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_store_queue
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
(
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  sq_push_t            i_push,
  input  logic [ADDR_W-1:0]   i_fwd_addr,
  output sq_fwd_t             o_fwd,
  input  commit_t             i_commit,
  output sq_drain_t           o_drain,
  input  logic                i_drain_ack,
  output logic [SQ_CNT_W-1:0] o_count
);

  typedef struct packed {
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [XLEN_W-1:0] data;
  } sq_entry_t;

  sq_entry_t           r_entry [SQ_DEPTH];
  logic [SQ_DEPTH-1:0] r_valid;
  logic [SQ_DEPTH-1:0] r_cmt;
  logic [SQ_PTR_W-1:0] r_head;
  logic [SQ_PTR_W-1:0] r_tail;
  logic [SQ_CNT_W-1:0] r_count;
  logic                w_pop;

  // --------------------
  // Forwarding search
  // --------------------
  // Walk oldest to youngest so the last match wins
  always_comb begin
    logic [SQ_PTR_W-1:0] idx;
    o_fwd = '0;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      idx = r_head + SQ_PTR_W'(i);
      if (r_valid[idx] &&
          r_entry[idx].addr[ADDR_W-1:BOFS_W] == i_fwd_addr[ADDR_W-1:BOFS_W]) begin
        o_fwd.hit  = 1'b1;
        o_fwd.data = r_entry[idx].data;
      end
    end
  end

  // --------------------
  // Drain, oldest first
  // --------------------
  assign o_drain = '{valid: r_valid[r_head] & r_cmt[r_head],
                     addr: r_entry[r_head].addr, data: r_entry[r_head].data};
  assign w_pop   = i_drain_ack & o_drain.valid;
  assign o_count = r_count;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      r_cmt   <= '0;
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else begin
      if (i_commit.valid) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
          if (r_valid[i] && r_entry[i].tag == i_commit.tag) begin
            r_cmt[i] <= 1'b1;
          end
        end
      end
      if (i_push.valid) begin
        r_valid[r_tail] <= 1'b1;
        r_cmt[r_tail]   <= 1'b0;
        r_tail          <= r_tail + SQ_PTR_W'(1);
      end
      if (w_pop) begin
        r_valid[r_head] <= 1'b0;
        r_head          <= r_head + SQ_PTR_W'(1);
      end
      r_count <= r_count + SQ_CNT_W'(i_push.valid) - SQ_CNT_W'(w_pop);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push.valid) begin
      r_entry[r_tail] <= '{tag: i_push.tag, addr: i_push.addr, data: i_push.data};
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_dcache
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic [ADDR_W-1:0] i_rd0_addr,
  output logic              o_rd0_hit,
  output logic [XLEN_W-1:0] o_rd0_data,
  input  logic [ADDR_W-1:0] i_rd1_addr,
  output logic              o_rd1_hit,
  output logic [XLEN_W-1:0] o_rd1_data,
  input  sq_drain_t         i_wr,
  input  refill_t           i_refill
);

  localparam int RD_PORTS = 2;

  logic [LINE_W-1:0]   r_data [LINE_NUM];
  logic [CTAG_W-1:0]   r_tag  [LINE_NUM];
  logic [LINE_NUM-1:0] r_valid;

  logic [ADDR_W-1:0]   w_rd_addr [RD_PORTS];
  logic                r_rd_hit  [RD_PORTS];
  logic [XLEN_W-1:0]   r_rd_data [RD_PORTS];

  logic [IDX_W-1:0]    w_wr_idx;
  logic [OFS_W-1:0]    w_wr_ofs;
  logic                w_wr_hit;
  logic [IDX_W-1:0]    w_rf_idx;

  assign w_rd_addr[0] = i_rd0_addr;
  assign w_rd_addr[1] = i_rd1_addr;
  assign o_rd0_hit    = r_rd_hit[0];
  assign o_rd0_data   = r_rd_data[0];
  assign o_rd1_hit    = r_rd_hit[1];
  assign o_rd1_data   = r_rd_data[1];

  // --------------------
  // Read ports
  // --------------------
  for (genvar p = 0; p < RD_PORTS; p++) begin : g_rd
    logic [IDX_W-1:0] w_idx;
    logic [OFS_W-1:0] w_ofs;
    logic             w_wr_same;

    assign w_idx = w_rd_addr[p][BOFS_W+OFS_W +: IDX_W];
    assign w_ofs = w_rd_addr[p][BOFS_W +: OFS_W];
    // Word written in this cycle is returned instead of the old copy
    assign w_wr_same = w_wr_hit &
                       (i_wr.addr[ADDR_W-1:BOFS_W] == w_rd_addr[p][ADDR_W-1:BOFS_W]);

    always_ff @(posedge i_clk or negedge i_reset_n) begin
      if (!i_reset_n) begin
        r_rd_hit[p] <= 1'b0;
      end else begin
        r_rd_hit[p] <= r_valid[w_idx] & (r_tag[w_idx] == w_rd_addr[p][ADDR_W-1 -: CTAG_W]);
      end
    end

    always_ff @(posedge i_clk) begin
      r_rd_data[p] <= w_wr_same ? i_wr.data : r_data[w_idx][w_ofs*XLEN_W +: XLEN_W];
    end
  end

  // --------------------
  // Word write, refill
  // --------------------
  assign w_wr_idx = i_wr.addr[BOFS_W+OFS_W +: IDX_W];
  assign w_wr_ofs = i_wr.addr[BOFS_W +: OFS_W];
  assign w_wr_hit = i_wr.valid & r_valid[w_wr_idx] &
                    (r_tag[w_wr_idx] == i_wr.addr[ADDR_W-1 -: CTAG_W]);
  assign w_rf_idx = i_refill.addr[BOFS_W+OFS_W +: IDX_W];

  always_ff @(posedge i_clk) begin
    if (i_refill.valid) begin
      r_data[w_rf_idx] <= i_refill.line;
      r_tag[w_rf_idx]  <= i_refill.addr[ADDR_W-1 -: CTAG_W];
    end else if (w_wr_hit) begin
      r_data[w_wr_idx][w_wr_ofs*XLEN_W +: XLEN_W] <= i_wr.data;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_refill.valid) begin
      r_valid[w_rf_idx] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_mem_requester.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_mem_requester
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_miss_valid,
  input  logic [ADDR_W-1:0] i_miss_addr,
  input  sq_drain_t         i_drain,
  output logic              o_drain_ack,
  output mem_req_t          o_mem_req,
  input  mem_resp_t         i_mem_resp,
  output refill_t           o_refill,
  output logic              o_refill_done
);

  typedef enum logic {
    IDLE,
    WAIT_RESP
  } state_e;

  state_e            r_state;
  logic [ADDR_W-1:0] r_line_addr;

  // Miss first, then drain; nothing goes out while a read is open
  always_comb begin
    o_mem_req   = '0;
    o_drain_ack = 1'b0;
    if (r_state == IDLE) begin
      if (i_miss_valid) begin
        o_mem_req.valid = 1'b1;
        o_mem_req.addr  = i_miss_addr;
      end else if (i_drain.valid) begin
        o_mem_req.valid    = 1'b1;
        o_mem_req.is_write = 1'b1;
        o_mem_req.addr     = i_drain.addr;
        o_mem_req.data     = i_drain.data;
        o_drain_ack        = 1'b1;
      end
    end
  end

  // Response goes straight into the cache
  assign o_refill_done = (r_state == WAIT_RESP) & i_mem_resp.valid;
  assign o_refill      = '{valid: o_refill_done, addr: r_line_addr, line: i_mem_resp.line};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= IDLE;
    end else begin
      case (r_state)
        IDLE:      if (i_miss_valid) r_state <= WAIT_RESP;
        WAIT_RESP: if (i_mem_resp.valid) r_state <= IDLE;
        default:   r_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (r_state == IDLE && i_miss_valid) begin
      r_line_addr <= i_miss_addr;
    end
  end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  disp_t     i_disp,
  input  commit_t   i_commit,
  input  mem_resp_t i_mem_resp,
  input  ptw_req_t  i_ptw_req,
  output logic      o_busy,
  output wr_t       o_ex3_wr,
  output done_t     o_done,
  output mem_req_t  o_mem_req,
  output ptw_resp_t o_ptw_resp
);

  disp_t               w_disp;
  logic [ADDR_W-1:0]   w_rd0_addr;
  logic                w_rd0_hit;
  logic [XLEN_W-1:0]   w_rd0_data;
  logic                w_rd1_hit;
  logic [XLEN_W-1:0]   w_rd1_data;
  logic [ADDR_W-1:0]   w_fwd_addr;
  sq_fwd_t             w_fwd;
  sq_push_t            w_sq_push;
  logic [1:0]          w_st_pend;
  logic                w_miss_valid;
  logic [ADDR_W-1:0]   w_miss_addr;
  logic                w_refill_done;
  refill_t             w_refill;
  logic                w_stall;
  logic [SQ_CNT_W-1:0] w_sq_count;
  logic [SQ_CNT_W:0]   w_sq_used;
  sq_drain_t           w_drain;
  logic                w_drain_ack;
  sq_drain_t           w_dc_wr;
  logic                r_ptw_valid;

  // --------------------
  // Back-pressure
  // --------------------
  // Queue entries plus stores still in EX1 and EX2
  assign w_sq_used = {1'b0, w_sq_count} + {{(SQ_CNT_W - 1){1'b0}}, w_st_pend};
  assign o_busy    = w_stall | (w_sq_used >= (SQ_CNT_W + 1)'(SQ_DEPTH));

  always_comb begin
    w_disp       = i_disp;
    w_disp.valid = i_disp.valid & ~o_busy;
  end

  // Drained store updates the cached copy too
  always_comb begin
    w_dc_wr       = w_drain;
    w_dc_wr.valid = w_drain_ack;
  end

  lsu_pipe u_pipe (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp       (w_disp),
    .o_rd_addr    (w_rd0_addr),
    .i_rd_hit     (w_rd0_hit),
    .i_rd_data    (w_rd0_data),
    .o_fwd_addr   (w_fwd_addr),
    .i_fwd        (w_fwd),
    .o_sq_push    (w_sq_push),
    .o_st_pend    (w_st_pend),
    .o_miss_valid (w_miss_valid),
    .o_miss_addr  (w_miss_addr),
    .i_refill_done(w_refill_done),
    .o_stall      (w_stall),
    .o_ex3_wr     (o_ex3_wr),
    .o_done       (o_done)
  );

  lsu_store_queue u_sq (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_push     (w_sq_push),
    .i_fwd_addr (w_fwd_addr),
    .o_fwd      (w_fwd),
    .i_commit   (i_commit),
    .o_drain    (w_drain),
    .i_drain_ack(w_drain_ack),
    .o_count    (w_sq_count)
  );

  lsu_dcache u_dcache (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_rd0_addr(w_rd0_addr),
    .o_rd0_hit (w_rd0_hit),
    .o_rd0_data(w_rd0_data),
    .i_rd1_addr(i_ptw_req.addr),
    .o_rd1_hit (w_rd1_hit),
    .o_rd1_data(w_rd1_data),
    .i_wr      (w_dc_wr),
    .i_refill  (w_refill)
  );

  lsu_mem_requester u_memreq (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_miss_valid (w_miss_valid),
    .i_miss_addr  (w_miss_addr),
    .i_drain      (w_drain),
    .o_drain_ack  (w_drain_ack),
    .o_mem_req    (o_mem_req),
    .i_mem_resp   (i_mem_resp),
    .o_refill     (w_refill),
    .o_refill_done(w_refill_done)
  );

  // --------------------
  // Walker read port
  // --------------------
  // Port 1 hit and data arrive together with the registered valid
  assign o_ptw_resp = '{valid: r_ptw_valid,
                        status: !r_ptw_valid ? NONE : (w_rd1_hit ? HIT : MISS),
                        data: w_rd1_data};

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ptw_valid <= 1'b0;
    end else begin
      r_ptw_valid <= i_ptw_req.valid;
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic o_clk
);

  // 40 ns period
  initial begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

//--- sim/lsu_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_asserts
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
(
  input logic      i_clk,
  input logic      i_reset_n,
  input logic      i_busy,
  input wr_t       i_ex3_wr,
  input done_t     i_done,
  input mem_req_t  i_mem_req,
  input mem_resp_t i_mem_resp,
  input ptw_req_t  i_ptw_req,
  input ptw_resp_t i_ptw_resp
);

  logic r_read_open;

  // Tracks the one external read in flight
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_read_open <= 1'b0;
    end else if (i_mem_req.valid && !i_mem_req.is_write) begin
      r_read_open <= 1'b1;
    end else if (i_mem_resp.valid) begin
      r_read_open <= 1'b0;
    end
  end

  a_wr_has_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ex3_wr.valid |-> i_done.valid && !i_done.is_store && i_done.tag == i_ex3_wr.tag)
    else $error("load writeback without a matching done report");

  a_one_read: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_mem_req.valid && !i_mem_req.is_write) |-> !r_read_open)
    else $error("external read issued while another is outstanding");

  a_ptw_follows: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ptw_req.valid |=> i_ptw_resp.valid)
    else $error("walker request without a response one cycle later");

  a_ptw_no_extra: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_ptw_resp.valid |-> $past(i_ptw_req.valid))
    else $error("walker response without a request one cycle earlier");

  a_idle_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !i_busy)
    else $error("busy high right after reset");

endmodule

bind lsu_top lsu_asserts i_asserts (
  .i_clk     (i_clk),
  .i_reset_n (i_reset_n),
  .i_busy    (o_busy),
  .i_ex3_wr  (o_ex3_wr),
  .i_done    (o_done),
  .i_mem_req (o_mem_req),
  .i_mem_resp(i_mem_resp),
  .i_ptw_req (i_ptw_req),
  .i_ptw_resp(o_ptw_resp)
);

`default_nettype wire

//--- sim/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
  import lsu_cfg_pkg::*, lsu_types_pkg::*;
();

  localparam int MEM_WORDS = 1 << (ADDR_W - BOFS_W);
  localparam int TAGS      = 1 << TAG_W;
  localparam int WAIT_MAX  = 400;
  localparam logic [31:0] SEED = 32'h7c8ece78;

  logic      clk;
  logic      reset_n;
  disp_t     disp;
  commit_t   commit;
  mem_resp_t mem_resp;
  ptw_req_t  ptw_req;
  logic      busy;
  wr_t       ex3_wr;
  done_t     done;
  mem_req_t  mem_req;
  ptw_resp_t ptw_resp;

  logic [XLEN_W-1:0] mem [MEM_WORDS];
  logic [ADDR_W-1:0] wlog_addr [$];
  logic [XLEN_W-1:0] wlog_data [$];
  logic [ADDR_W-1:0] st_addr [$];
  logic [XLEN_W-1:0] st_data [$];
  int                pend [$];

  // Issue side and result side of the scoreboard, indexed by tag
  logic [XLEN_W-1:0] exp_data [TAGS];
  logic              exp_st [TAGS];
  int                iss_wr_cnt [TAGS];
  int                iss_done_cnt [TAGS];
  int                disp_cyc [TAGS];
  int                got_wr_cnt [TAGS];
  int                got_done_cnt [TAGS];
  int                wr_cyc [TAGS];

  integer            seed;
  integer            lat_seed;
  int                cyc;
  int                op_seq;
  int                issued_total;
  int                done_total;
  int                commit_cnt;
  int                check_cnt;
  int                err_cnt;
  int                test_err0;
  int                n0;
  logic [31:0]       rnd;
  logic [ADDR_W-1:0] addr;
  logic [TAG_W-1:0]  t0;
  logic [TAG_W-1:0]  st_tag [4];

  tb_clkgen u_clkgen (.o_clk(clk));

  lsu_top i_dut (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_disp    (disp),
    .i_commit  (commit),
    .i_mem_resp(mem_resp),
    .i_ptw_req (ptw_req),
    .o_busy    (busy),
    .o_ex3_wr  (ex3_wr),
    .o_done    (done),
    .o_mem_req (mem_req),
    .o_ptw_resp(ptw_resp)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // --------------------
  // Reference model
  // --------------------
  function automatic logic [XLEN_W-1:0] pattern(input logic [ADDR_W-1:0] a);
    return {a ^ 16'hA5C3, ~a + 16'h1234};
  endfunction

  // Youngest earlier store in program order, else memory
  function automatic logic [XLEN_W-1:0] expected_load(input logic [ADDR_W-1:0] a);
    for (int i = st_addr.size() - 1; i >= 0; i--) begin
      if (st_addr[i] == a) begin
        return st_data[i];
      end
    end
    return mem[a[ADDR_W-1:BOFS_W]];
  endfunction

  function automatic logic [LINE_W-1:0] line_of(input logic [ADDR_W-1:0] a);
    logic [LINE_W-1:0]        line;
    logic [ADDR_W-BOFS_W-1:0] base;
    base = {a[ADDR_W-1:OFS_W+BOFS_W], {OFS_W{1'b0}}};
    for (int w = 0; w < LINE_WORDS; w++) begin
      line[w*XLEN_W +: XLEN_W] = mem[base + (ADDR_W - BOFS_W)'(w)];
    end
    return line;
  endfunction

  // --------------------
  // Reporting
  // --------------------
  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t ns: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic abort_on_timeout(input string what);
    err_cnt++;
    $display("Timeout at %0t ns while waiting for %s", $time, what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic end_test(input string name);
    if (err_cnt == test_err0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d errors", name, err_cnt - test_err0);
    end
    test_err0 = err_cnt;
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------
  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy) begin
      @(negedge clk);
      n++;
      if (n > WAIT_MAX) abort_on_timeout("o_busy to drop");
    end
  endtask

  task automatic issue(input logic is_store, input logic [ADDR_W-1:0] a,
                       input logic [XLEN_W-1:0] data, output logic [TAG_W-1:0] tag);
    tag = op_seq[TAG_W-1:0];
    wait_not_busy();
    disp.valid    = 1'b1;
    disp.is_store = is_store;
    disp.tag      = tag;
    disp.data     = data;
    // Alternate negative and positive immediates
    if (op_seq[0]) begin
      disp.offset = 12'hFF8;
      disp.base   = 32'(a) + 32'd8;
    end else begin
      disp.offset = 12'h00C;
      disp.base   = 32'(a) - 32'd12;
    end
    if (is_store) begin
      st_addr.push_back(a);
      st_data.push_back(data);
    end else begin
      exp_data[tag] = expected_load(a);
      iss_wr_cnt[tag]++;
    end
    exp_st[tag] = is_store;
    iss_done_cnt[tag]++;
    disp_cyc[tag] = cyc;
    issued_total++;
    op_seq++;
    @(negedge clk);
    disp.valid = 1'b0;
  endtask

  task automatic wait_done(input logic [TAG_W-1:0] tag);
    int n;
    n = 0;
    while (got_done_cnt[tag] != iss_done_cnt[tag]) begin
      @(negedge clk);
      n++;
      if (n > WAIT_MAX) abort_on_timeout($sformatf("o_done of tag %0d", tag));
    end
  endtask

  // Every finished load must also have produced its writeback
  task automatic wait_idle();
    int n;
    n = 0;
    while (done_total != issued_total) begin
      @(negedge clk);
      n++;
      if (n > WAIT_MAX) abort_on_timeout("all operations to complete");
    end
    for (int t = 0; t < TAGS; t++) begin
      check_value($sformatf("o_ex3_wr count (tag %0d)", t), 32'(got_wr_cnt[t]),
                  32'(iss_wr_cnt[t]));
    end
  endtask

  task automatic wait_writes(input int count);
    int n;
    n = 0;
    while (wlog_addr.size() < count) begin
      @(negedge clk);
      n++;
      if (n > WAIT_MAX) abort_on_timeout("store drain writes");
    end
  endtask

  // Commit is only seen by the queue once the store has left EX2
  task automatic commit_store(input logic [TAG_W-1:0] tag);
    wait_done(tag);
    commit.valid = 1'b1;
    commit.tag   = tag;
    commit_cnt++;
    @(negedge clk);
    commit.valid = 1'b0;
  endtask

  task automatic commit_oldest();
    int s;
    s = pend.pop_front();
    commit_store(s[TAG_W-1:0]);
  endtask

  task automatic ptw_probe(input logic [ADDR_W-1:0] a, input ptw_status_e exp_status,
                           input logic [XLEN_W-1:0] exp_word);
    ptw_req.valid = 1'b1;
    ptw_req.addr  = a;
    @(negedge clk);
    ptw_req.valid = 1'b0;
    check_value("o_ptw_resp.valid", 32'(ptw_resp.valid), 32'd1);
    check_value("o_ptw_resp.status", 32'(ptw_resp.status), 32'(exp_status));
    if (exp_status == HIT) begin
      check_value("o_ptw_resp.data", ptw_resp.data, exp_word);
    end
    @(negedge clk);
    check_value("o_ptw_resp.valid", 32'(ptw_resp.valid), 32'd0);
  endtask

  // --------------------
  // Memory model
  // --------------------
  initial begin
    int resp_wait;
    logic [ADDR_W-1:0] resp_addr;
    logic [31:0] lat_rnd;
    mem_resp  = '0;
    resp_wait = 0;
    resp_addr = '0;
    lat_seed  = SEED;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = pattern(ADDR_W'(i << BOFS_W));
    end
    forever begin
      @(negedge clk);
      mem_resp.valid = 1'b0;
      if (resp_wait > 0) begin
        resp_wait--;
        if (resp_wait == 0) begin
          mem_resp.valid = 1'b1;
          mem_resp.line  = line_of(resp_addr);
        end
      end
      if (reset_n && mem_req.valid) begin
        if (mem_req.is_write) begin
          mem[mem_req.addr[ADDR_W-1:BOFS_W]] = mem_req.data;
          wlog_addr.push_back(mem_req.addr);
          wlog_data.push_back(mem_req.data);
        end else begin
          if (resp_wait != 0) report_failure("Second refill read while one is outstanding");
          lat_rnd   = $random(lat_seed);
          resp_addr = mem_req.addr;
          resp_wait = 2 + int'(lat_rnd[7:0] % 8'd7);
        end
      end
    end
  end

  // --------------------
  // Compare process
  // --------------------
  always @(negedge clk) begin
    if (reset_n) begin
      if (ex3_wr.valid) begin
        if (got_wr_cnt[ex3_wr.tag] == iss_wr_cnt[ex3_wr.tag]) begin
          report_failure($sformatf("Writeback for tag %0d with no load in flight", ex3_wr.tag));
        end else begin
          check_value($sformatf("o_ex3_wr.data (tag %0d)", ex3_wr.tag), ex3_wr.data,
                      exp_data[ex3_wr.tag]);
          got_wr_cnt[ex3_wr.tag]++;
          wr_cyc[ex3_wr.tag] = cyc;
        end
      end
      if (done.valid) begin
        if (got_done_cnt[done.tag] == iss_done_cnt[done.tag]) begin
          report_failure($sformatf("Done report for tag %0d with nothing in flight", done.tag));
        end else begin
          check_value($sformatf("o_done.is_store (tag %0d)", done.tag), 32'(done.is_store),
                      32'(exp_st[done.tag]));
          got_done_cnt[done.tag]++;
          done_total++;
        end
      end
    end
  end

  // --------------------
  // Tests
  // --------------------
  initial begin
    reset_n = 1'b0;
    disp    = '0;
    commit  = '0;
    ptw_req = '0;
    seed    = SEED;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    check_value("o_busy", 32'(busy), 32'd0);
    check_value("o_ex3_wr.valid", 32'(ex3_wr.valid), 32'd0);
    check_value("o_done.valid", 32'(done.valid), 32'd0);
    check_value("o_mem_req.valid", 32'(mem_req.valid), 32'd0);
    check_value("o_ptw_resp.valid", 32'(ptw_resp.valid), 32'd0);
    end_test("0 reset state");

    // Cold miss, then a hit in the same line
    issue(1'b0, 16'h0120, '0, t0);
    wait_idle();
    issue(1'b0, 16'h0124, '0, t0);
    wait_idle();
    check_value("load hit latency", 32'(wr_cyc[t0] - disp_cyc[t0]), 32'd3);
    end_test("1 miss then hit");

    issue(1'b1, 16'h0200, 32'hCAFE_0001, st_tag[0]);
    issue(1'b0, 16'h0200, '0, t0);
    wait_idle();
    n0 = wlog_addr.size();
    commit_store(st_tag[0]);
    wait_writes(n0 + 1);
    end_test("2 store forwarding");

    issue(1'b0, 16'h0340, '0, t0);
    for (int k = 0; k < 3; k++) begin
      issue(1'b1, 16'h0340 + 16'(4 * k), 32'hD00D_0000 + 32'(k), st_tag[k]);
    end
    n0 = wlog_addr.size();
    for (int k = 0; k < 3; k++) begin
      commit_store(st_tag[k]);
    end
    wait_writes(n0 + 3);
    for (int k = 0; k < 3; k++) begin
      check_value("o_mem_req.addr", 32'(wlog_addr[n0 + k]), 32'(16'h0340 + 16'(4 * k)));
      check_value("o_mem_req.data", wlog_data[n0 + k], 32'hD00D_0000 + 32'(k));
    end
    wait_idle();
    issue(1'b0, 16'h0344, '0, t0);
    issue(1'b0, 16'h0200, '0, t0);
    wait_idle();
    end_test("3 commit and drain");

    ptw_probe(16'h0120, HIT, expected_load(16'h0120));
    ptw_probe(16'h0344, HIT, expected_load(16'h0344));
    ptw_probe(16'h7F00, MISS, '0);
    end_test("4 walker port");

    for (int k = 0; k < 4; k++) begin
      issue(1'b1, 16'h0480 + 16'(4 * k), 32'hBEEF_0000 + 32'(k), st_tag[k]);
    end
    // Queue is full of uncommitted stores, so busy must hold
    for (int k = 0; k < 4; k++) begin
      check_value("o_busy", 32'(busy), 32'd1);
      @(negedge clk);
    end
    commit_store(st_tag[0]);
    issue(1'b0, 16'h0488, '0, t0);
    for (int k = 1; k < 4; k++) begin
      commit_store(st_tag[k]);
    end
    wait_idle();
    wait_writes(commit_cnt);
    end_test("5 back-pressure");

    for (int i = 0; i < 200; i++) begin
      rnd = $random(seed);
      while (pend.size() > 0 && op_seq - pend[0] >= 12) begin
        commit_oldest();
      end
      if (pend.size() >= 3 || (pend.size() > 0 && rnd[1:0] == 2'd3)) begin
        commit_oldest();
      end else begin
        addr = {4'h0, 3'b100, rnd[8], 2'b00, rnd[12:9], 2'b00};
        if (rnd[2]) begin
          pend.push_back(op_seq);
          issue(1'b1, addr, $random(seed), t0);
        end else begin
          issue(1'b0, addr, '0, t0);
        end
      end
    end
    while (pend.size() > 0) begin
      commit_oldest();
    end
    wait_idle();
    wait_writes(commit_cnt);
    end_test("6 random mix");

    $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hw/lsu_cfg_pkg.sv
hw/lsu_types_pkg.sv
hw/lsu_pipe.sv
hw/lsu_store_queue.sv
hw/lsu_dcache.sv
hw/lsu_mem_requester.sv
hw/lsu_top.sv
sim/tb_clkgen.sv
sim/lsu_asserts.sv
sim/lsu_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = lsu_tb
FILE_LIST = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
